//--- verilog.f
+incdir+source
source/ahbl_pkg.sv
source/ppu_fetch_pkg.sv
source/ppu_busmaster.sv
source/ppu_bg_fetch.sv
source/ppu_palette_fetch.sv
source/ppu_vram.sv
source/ppu_fetch_top.sv
verification/ppu_fetch_sva.sv
verification/ppu_fetch_checker.sv
verification/ppu_fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the pixel fetch testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module ppu_fetch_tb \
	-f verilog.f -o ppu_fetch_sim

# Let the run reach its own summary even after an assertion has fired
./obj_dir/ppu_fetch_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "^TEST OK$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

//--- verification/ppu_fetch_tb.sv
`default_nettype none

`include "ppu_bus_defines.svh"

module ppu_fetch_tb;

	localparam int n_loads = 12;
	localparam int n_rows = 8;
	localparam int n_passes = 2;
	localparam int reset_cycles = 5;
	localparam int idle_cycles = 20;
	localparam int drain_limit = 256;

	// Watchdog budget per row and pass, plus the fixed setup at the start
	localparam int watchdog_cycles = n_rows * n_passes * 64 + n_loads + reset_cycles
		+ idle_cycles + drain_limit;

	// --------------------------------------------------
	// Video RAM image as word address and data
	// Map words hold entries 0 to 3, tiles 2, 5 and 7 follow, then palette words
	localparam logic [39:0] load_table [n_loads] = '{
		{8'h00, 32'h00C5_0042},
		{8'h01, 32'hA482_0007},
		{8'h42, 32'hF005_A413},
		{8'h45, 32'h1B2A_3C4D},
		{8'h47, 32'h0908_0706},
		{8'h84, 32'h7C00_03E0},
		{8'h89, 32'h1234_5555},
		{8'h8A, 32'h6666_BEEF},
		{8'h90, 32'h7777_001F},
		{8'h91, 32'h4321_8888},
		{8'h9D, 32'h9999_CAFE},
		{8'h9E, 32'hAAAA_0F0F}
	};

	// Pixel requests as map_index, pix and expected rgb
	// Odd map indices use the upper map halfword, all four pix lanes appear
	localparam logic [24:0] pixel_table [n_rows] = '{
		{7'd0, 2'd0, 16'h1234},
		{7'd1, 2'd1, 16'h0F0F},
		{7'd2, 2'd2, 16'h03E0},
		{7'd3, 2'd3, 16'h001F},
		{7'd0, 2'd1, 16'hBEEF},
		{7'd1, 2'd2, 16'hCAFE},
		{7'd2, 2'd3, 16'h7C00},
		{7'd3, 2'd0, 16'h4321}
	};

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic                   pixel_req;
	logic [6:0]             map_index;
	logic [1:0]             pix;
	logic                   pixel_busy;
	logic                   pixel_vld;
	logic [15:0]            pixel_rgb;
	logic                   load_en;
	logic [7:0]             load_addr;
	logic [`PPU_W_DATA-1:0] load_data;
	logic                   stall = 1'b0;

	logic        exp_vld;
	logic [15:0] exp_rgb;
	logic        idle_check;
	logic        stall_on;
	logic        stall_next;
	logic [31:0] lfsr = 32'h6eb687ea;
	int          err_count;
	int          checked;
	int          outstanding;

	always #5 clk = ~clk;

	ppu_fetch_top i_ppu_fetch_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.pixel_req  (pixel_req),
		.map_index  (map_index),
		.pix        (pix),
		.pixel_busy (pixel_busy),
		.pixel_vld  (pixel_vld),
		.pixel_rgb  (pixel_rgb),
		.load_en    (load_en),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.stall      (stall)
	);

	ppu_fetch_checker i_ppu_fetch_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.pixel_vld   (pixel_vld),
		.pixel_rgb   (pixel_rgb),
		.pixel_busy  (pixel_busy),
		.exp_vld     (exp_vld),
		.exp_rgb     (exp_rgb),
		.idle_check  (idle_check),
		.err_count   (err_count),
		.checked     (checked),
		.outstanding (outstanding)
	);

	bind ppu_busmaster ppu_fetch_sva i_ppu_fetch_sva (
		.clk     (clk),
		.rst_n   (rst_n),
		.req_vld (req_vld),
		.req_rdy (req_rdy),
		.haddr   (haddr),
		.htrans  (htrans),
		.hsize   (hsize),
		.hready  (hready)
	);

	// Galois LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	// One stall bit per cycle, decided at the edge and driven just after it
	always @(posedge clk) begin
		stall_next = stall_on ? lfsr[0] : 1'b0;
		if (stall_on) begin
			lfsr = lfsr_step(lfsr);
		end
		#1 stall = stall_next;
	end

	// --------------------------------------------------
	// Stimulus tasks, entered and left just after a rising edge

	task automatic issue_pixel(input logic [24:0] row);
		// The next request goes in as soon as the background fetcher is free
		while (pixel_busy) begin
			@(posedge clk);
			#1;
		end
		pixel_req = 1'b1;
		map_index = row[24:18];
		pix = row[17:16];
		exp_vld = 1'b1;
		exp_rgb = row[15:0];
		@(posedge clk);
		#1;
		pixel_req = 1'b0;
		exp_vld = 1'b0;
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while ((outstanding != 0 || pixel_busy) && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
	endtask

	initial begin
		int missing;
		int assert_fails;
		rst_n = 1'b0;
		pixel_req = 1'b0;
		map_index = '0;
		pix = '0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		exp_vld = 1'b0;
		exp_rgb = '0;
		idle_check = 1'b0;
		stall_on = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Fill the video RAM before any fetch
		for (int i = 0; i < n_loads; i++) begin
			load_en = 1'b1;
			load_addr = load_table[i][39:32];
			load_data = load_table[i][31:0];
			@(posedge clk);
			#1;
		end
		load_en = 1'b0;

		idle_check = 1'b1;
		repeat (idle_cycles) @(posedge clk);
		#1;
		idle_check = 1'b0;

		// First pass runs without stall, the second under random back-pressure
		for (int p = 0; p < n_passes; p++) begin
			stall_on = p == 1;
			for (int i = 0; i < n_rows; i++) begin
				issue_pixel(pixel_table[i]);
			end
			wait_drain(drain_limit);
		end
		stall_on = 1'b0;

		missing = outstanding;
		assert_fails = i_ppu_fetch_top.i_ppu_busmaster.i_ppu_fetch_sva.fail_count;
		if (missing != 0) begin
			$display("%0d expected pixels never arrived", missing);
		end
		$display("Summary: %0d checked, %0d errors, %0d missing, %0d assertion failures",
			checked, err_count, missing, assert_fails);
		if (err_count == 0 && missing == 0 && assert_fails == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout after %0d cycles with %0d expected pixels still outstanding",
			watchdog_cycles, outstanding);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/ppu_fetch_checker.sv
`default_nettype none

module ppu_fetch_checker (
	input  wire        clk,
	input  wire        rst_n,

	// Watched DUT outputs
	input  wire        pixel_vld,
	input  wire [15:0] pixel_rgb,
	input  wire        pixel_busy,

	// Expected values from the stimulus side
	input  wire        exp_vld,
	input  wire [15:0] exp_rgb,
	input  wire        idle_check,

	output int         err_count,
	output int         checked,
	output int         outstanding
);

	// Expected pixels in request order
	logic [15:0] exp_q [$];
	logic [15:0] exp_head;

	initial begin
		err_count = 0;
		checked = 0;
		outstanding = 0;
	end

	// DUT outputs change on NBA, so sampling at the edge sees settled values
	always @(posedge clk) begin
		if (rst_n) begin
			// Nothing may move while no request has been made
			if (idle_check && (pixel_vld || pixel_busy)) begin
				$display("FAILED at %0t: pixel_vld=%b pixel_busy=%b with no request",
					$time, pixel_vld, pixel_busy);
				err_count++;
			end
			if (pixel_vld) begin
				if (exp_q.size() == 0) begin
					$display("Unexpected pixel %h at %0t while no request was outstanding",
						pixel_rgb, $time);
					err_count++;
				end else begin
					exp_head = exp_q.pop_front();
					checked++;
					if (pixel_rgb !== exp_head) begin
						$display("FAILED at %0t: pixel %0d rgb %h, expected %h",
							$time, checked, pixel_rgb, exp_head);
						err_count++;
					end
				end
			end
			// A pixel never returns in the cycle of its own request, so pushing last is safe
			if (exp_vld) begin
				exp_q.push_back(exp_rgb);
			end
			outstanding = exp_q.size();
		end
	end

endmodule

`default_nettype wire

//--- verification/ppu_fetch_sva.sv
`default_nettype none

`include "ppu_bus_defines.svh"

module ppu_fetch_sva
	import ahbl_pkg::*;
(
	input wire                   clk,
	input wire                   rst_n,
	input wire [`PPU_N_REQ-1:0]  req_vld,
	input wire [`PPU_N_REQ-1:0]  req_rdy,
	input wire [`PPU_W_ADDR-1:0] haddr,
	input htrans_t               htrans,
	input hsize_t                hsize,
	input wire                   hready
);

	// Read back by the testbench at the end of the run
	int fail_count = 0;

	// --------------------------------------------------
	// AHB-lite master port rules

	// A stalled address phase keeps its attributes until it is taken
	stable_aph: assert property (@(posedge clk) disable iff (!rst_n)
		(htrans == HTRANS_NONSEQ && !hready) |=> ($stable(haddr) && $stable(hsize)))
	else begin
		$error("haddr or hsize changed while a NONSEQ transfer was stalled");
		fail_count++;
	end

	// No requester, no transfer
	idle_no_req: assert property (@(posedge clk) disable iff (!rst_n)
		!(|req_vld) |-> htrans == HTRANS_IDLE)
	else begin
		$error("htrans is not IDLE although no requester is valid");
		fail_count++;
	end

	// Ready goes to at most one requester, and only to one still holding its request
	rdy_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(req_rdy) && (req_rdy & ~req_vld) == '0)
	else begin
		$error("req_rdy is not one-hot or is given to a requester without req_vld");
		fail_count++;
	end

endmodule

`default_nettype wire

//--- source/ppu_fetch_top.sv
`default_nettype none

`include "ppu_bus_defines.svh"

module ppu_fetch_top
	import ahbl_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst_n,

	// Host pixel interface
	input  wire                    pixel_req,
	input  wire  [6:0]             map_index,
	input  wire  [1:0]             pix,
	output logic                   pixel_busy,
	output logic                   pixel_vld,
	output logic [15:0]            pixel_rgb,

	// Video RAM load and back-pressure
	input  wire                    load_en,
	input  wire  [7:0]             load_addr,
	input  wire  [`PPU_W_DATA-1:0] load_data,
	input  wire                    stall
);

	// Packed requester buses, index 0 is the palette fetcher
	logic [`PPU_N_REQ-1:0]             req_vld;
	logic [`PPU_N_REQ*`PPU_W_ADDR-1:0] req_addr;
	logic [`PPU_N_REQ*2-1:0]           req_size;
	logic [`PPU_N_REQ-1:0]             req_rdy;
	logic [`PPU_W_DATA-1:0]            req_data;

	// Handoff between the two fetchers
	logic       idx_vld;
	logic [3:0] idx_colour;
	logic [2:0] idx_pal;
	logic       idx_busy;

	// AHB-lite between master and video RAM
	logic [`PPU_W_ADDR-1:0] haddr;
	htrans_t                htrans;
	logic                   hready;
	logic [`PPU_W_DATA-1:0] hrdata;

	ppu_busmaster i_ppu_busmaster (
		.clk      (clk),
		.rst_n    (rst_n),
		.req_vld  (req_vld),
		.req_addr (req_addr),
		.req_size (req_size),
		.req_rdy  (req_rdy),
		.req_data (req_data),
		.haddr    (haddr),
		.htrans   (htrans),
		// The video RAM always returns a full word, so size is not routed
		.hsize    (),
		.hready   (hready),
		.hrdata   (hrdata)
	);

	ppu_bg_fetch i_ppu_bg_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.pixel_req  (pixel_req),
		.map_index  (map_index),
		.pix        (pix),
		.pixel_busy (pixel_busy),
		.req_vld    (req_vld[1]),
		.req_addr   (req_addr[`PPU_W_ADDR +: `PPU_W_ADDR]),
		.req_size   (req_size[3:2]),
		.req_rdy    (req_rdy[1]),
		.req_data   (req_data),
		.idx_vld    (idx_vld),
		.idx_colour (idx_colour),
		.idx_pal    (idx_pal),
		.idx_busy   (idx_busy)
	);

	ppu_palette_fetch i_ppu_palette_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.idx_vld    (idx_vld),
		.idx_colour (idx_colour),
		.idx_pal    (idx_pal),
		.idx_busy   (idx_busy),
		.req_vld    (req_vld[0]),
		.req_addr   (req_addr[0 +: `PPU_W_ADDR]),
		.req_size   (req_size[1:0]),
		.req_rdy    (req_rdy[0]),
		.req_data   (req_data),
		.pixel_vld  (pixel_vld),
		.pixel_rgb  (pixel_rgb)
	);

	ppu_vram i_ppu_vram (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.stall     (stall),
		.haddr     (haddr),
		.htrans    (htrans),
		.hready    (hready),
		.hrdata    (hrdata)
	);

endmodule

`default_nettype wire

//--- source/ppu_vram.sv
`default_nettype none

`include "ppu_bus_defines.svh"

module ppu_vram
	import ahbl_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst_n,

	// Host load port, one word per cycle
	input  wire                    load_en,
	input  wire  [7:0]             load_addr,
	input  wire  [`PPU_W_DATA-1:0] load_data,

	// External back-pressure
	input  wire                    stall,

	// AHB-lite slave port, read only
	input  wire  [`PPU_W_ADDR-1:0] haddr,
	input  htrans_t                htrans,
	output logic                   hready,
	output logic [`PPU_W_DATA-1:0] hrdata
);

	logic [`PPU_W_DATA-1:0] mem [`PPU_VRAM_WORDS];
	logic [`PPU_W_DATA-1:0] rdata;
	logic                   aph_take;
	logic                   dph_vld;

	// Zero wait states unless stalled, every stall cycle adds one
	assign hready = !stall;

	// An address phase is accepted when hready is high at its end
	assign aph_take = hready && htrans == HTRANS_NONSEQ;

	// Read data is captured at the end of the address phase and held
	// through any stall, since no new phase is accepted meanwhile
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end
		if (aph_take) begin
			rdata <= mem[haddr[9:2]];
		end
	end

	// Tracks whether the current cycle is a live data phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_vld <= 1'b0;
		end else if (hready) begin
			dph_vld <= aph_take;
		end
	end

	// Bus reads zero outside a data phase
	assign hrdata = dph_vld ? rdata : '0;

endmodule

`default_nettype wire

//--- source/ppu_palette_fetch.sv
`default_nettype none

`include "ppu_bus_defines.svh"

module ppu_palette_fetch
	import ahbl_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst_n,

	// Colour index from the background fetcher
	input  wire                    idx_vld,
	input  wire  [3:0]             idx_colour,
	input  wire  [2:0]             idx_pal,
	output logic                   idx_busy,

	// Requester port towards the bus master
	output logic                   req_vld,
	output logic [`PPU_W_ADDR-1:0] req_addr,
	output logic [1:0]             req_size,
	input  wire                    req_rdy,
	input  wire  [`PPU_W_DATA-1:0] req_data,

	// Finished pixel
	output logic                   pixel_vld,
	output logic [15:0]            pixel_rgb
);

	logic       pending;
	logic [3:0] colour_q;
	logic [2:0] pal_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
			pixel_vld <= 1'b0;
		end else begin
			pixel_vld <= pending && req_rdy;
			if (idx_vld) begin
				pending <= 1'b1;
			end else if (req_rdy) begin
				pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (idx_vld) begin
			colour_q <= idx_colour;
			pal_q <= idx_pal;
		end
		// Steered halfword of the palette entry is in the low 16 bits
		if (pending && req_rdy) begin
			pixel_rgb <= req_data[15:0];
		end
	end

	// Busy covers the pixel output cycle too, so a new index never lands early
	assign idx_busy = pending || pixel_vld;

	// Sixteen halfword colours per palette
	assign req_vld = pending;
	assign req_addr = `PPU_PAL_BASE + {pal_q, colour_q, 1'b0};
	assign req_size = 2'(HSIZE_HALF);

endmodule

`default_nettype wire

//--- source/ppu_bg_fetch.sv
`default_nettype none

`include "ppu_bus_defines.svh"

module ppu_bg_fetch
	import ahbl_pkg::*;
	import ppu_fetch_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst_n,

	// Host pixel request
	input  wire                    pixel_req,
	input  wire  [6:0]             map_index,
	input  wire  [1:0]             pix,
	output logic                   pixel_busy,

	// Requester port towards the bus master
	output logic                   req_vld,
	output logic [`PPU_W_ADDR-1:0] req_addr,
	output logic [1:0]             req_size,
	input  wire                    req_rdy,
	input  fetch_word_u            req_data,

	// Colour index handoff to the palette fetcher
	output logic                   idx_vld,
	output logic [3:0]             idx_colour,
	output logic [2:0]             idx_pal,
	input  wire                    idx_busy
);

	typedef enum logic [1:0] {
		BG_IDLE,
		BG_MAP,
		BG_TILE,
		BG_HAND
	} bg_state_t;

	bg_state_t  state;
	logic [6:0] map_index_q;
	logic [1:0] pix_q;
	logic [5:0] tile_q;
	logic [2:0] pal_q;
	logic [3:0] colour_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= BG_IDLE;
		end else begin
			case (state)
				BG_IDLE: if (pixel_req) state <= BG_MAP;
				BG_MAP:  if (req_rdy) state <= BG_TILE;
				BG_TILE: if (req_rdy) state <= BG_HAND;
				BG_HAND: if (!idx_busy) state <= BG_IDLE;
				default: state <= BG_IDLE;
			endcase
		end
	end

	// Request fields and fetched values are captured as each step completes
	always_ff @(posedge clk) begin
		if (state == BG_IDLE && pixel_req) begin
			map_index_q <= map_index;
			pix_q <= pix;
		end
		if (state == BG_MAP && req_rdy) begin
			tile_q <= req_data.map.entry.tile;
			pal_q <= req_data.map.entry.pal;
		end
		if (state == BG_TILE && req_rdy) begin
			colour_q <= req_data.bytes[0][3:0];
		end
	end

	// Tilemap entries are halfwords, tile rows are four bytes
	assign req_vld = state == BG_MAP || state == BG_TILE;
	assign req_addr = state == BG_MAP ? `PPU_MAP_BASE + {map_index_q, 1'b0} :
		`PPU_TILE_BASE + {tile_q, pix_q};
	assign req_size = state == BG_MAP ? 2'(HSIZE_HALF) : 2'(HSIZE_BYTE);

	assign pixel_busy = state != BG_IDLE;

	// Handoff stalls here while the palette fetcher still owns a pixel
	assign idx_vld = state == BG_HAND && !idx_busy;
	assign idx_colour = colour_q;
	assign idx_pal = pal_q;

endmodule

`default_nettype wire

//--- source/ppu_busmaster.sv
`default_nettype none

`include "ppu_bus_defines.svh"

module ppu_busmaster
	import ahbl_pkg::*;
(
	input  wire                                  clk,
	input  wire                                  rst_n,

	// Requester side, one slice per requester
	input  wire  [`PPU_N_REQ-1:0]                req_vld,
	input  wire  [`PPU_N_REQ*`PPU_W_ADDR-1:0]    req_addr,
	input  wire  [`PPU_N_REQ*2-1:0]              req_size,
	output logic [`PPU_N_REQ-1:0]                req_rdy,
	output logic [`PPU_W_DATA-1:0]               req_data,

	// AHB-lite master port, read only
	output logic [`PPU_W_ADDR-1:0]               haddr,
	output htrans_t                              htrans,
	output hsize_t                               hsize,
	input  wire                                  hready,
	input  wire  [`PPU_W_DATA-1:0]               hrdata
);

	// --------------------------------------------------
	// Arbitration

	logic [`PPU_N_REQ-1:0] req_vld_aph;
	logic [`PPU_N_REQ-1:0] grant_aph_comb;
	logic [`PPU_N_REQ-1:0] grant_aph_reg;
	logic [`PPU_N_REQ-1:0] grant_aph;
	logic [`PPU_N_REQ-1:0] grant_dph;

	// A requester in its data phase still holds req_vld until its ready,
	// so it is kept out of arbitration and its read is not issued twice
	assign req_vld_aph = req_vld & ~grant_dph;

	// Lowest set bit of the remaining requests wins
	assign grant_aph_comb = req_vld_aph & (~req_vld_aph + 1'b1);

	// While the bus is stalled the grant of the pending address phase is held,
	// so a newly arriving lower-numbered request cannot steal it
	assign grant_aph = |grant_aph_reg ? grant_aph_reg : grant_aph_comb;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant_aph_reg <= '0;
			grant_dph <= '0;
		end else if (hready) begin
			// Address phase is taken, its owner moves into the data phase
			grant_aph_reg <= '0;
			grant_dph <= grant_aph;
		end else begin
			grant_aph_reg <= grant_aph;
		end
	end

	// --------------------------------------------------
	// Address phase attributes

	logic [`PPU_W_ADDR-1:0] addr_sel;
	logic [1:0]             size_sel;
	logic [`PPU_W_ADDR-1:0] aph_buf_addr;
	logic [1:0]             aph_buf_size;
	logic                   use_buf;

	// One-hot mux of the combinational winner's address and size
	always_comb begin
		addr_sel = '0;
		size_sel = '0;
		for (int i = 0; i < `PPU_N_REQ; i++) begin
			if (grant_aph_comb[i]) begin
				addr_sel = addr_sel | req_addr[i*`PPU_W_ADDR +: `PPU_W_ADDR];
				size_sel = size_sel | req_size[i*2 +: 2];
			end
		end
	end

	// Once a stall has been seen, attributes come from the buffer until hready
	assign use_buf = |grant_aph_reg;

	always_ff @(posedge clk) begin
		if (|req_vld_aph && !use_buf && !hready) begin
			aph_buf_addr <= addr_sel;
			aph_buf_size <= size_sel;
		end
	end

	assign haddr = use_buf ? aph_buf_addr : addr_sel;
	assign hsize = hsize_t'({1'b0, use_buf ? aph_buf_size : size_sel});
	assign htrans = |grant_aph ? HTRANS_NONSEQ : HTRANS_IDLE;

	// --------------------------------------------------
	// Data phase steering

	logic [1:0]             dph_addr;
	logic [`PPU_W_DATA-1:0] hrdata_steered;

	// Low address bits follow the transfer into its data phase
	always_ff @(posedge clk) begin
		if (hready) begin
			dph_addr <= haddr[1:0];
		end
	end

	// Addressed byte lands in byte 0
	// Byte 1 carries the upper byte of whichever halfword was addressed
	assign hrdata_steered = {
		hrdata[31:16],
		dph_addr[1] ? hrdata[31:24] : hrdata[15:8],
		hrdata[{dph_addr, 3'b000} +: 8]
	};

	// Ready pulses once, for the owner, when the data phase completes
	assign req_rdy = grant_dph & {`PPU_N_REQ{hready}};
	assign req_data = hrdata_steered;

endmodule

`default_nettype wire

//--- source/ppu_fetch_pkg.sv
`default_nettype none

package ppu_fetch_pkg;

	// One halfword of the tilemap
	// Tile number sits in the low bits, palette select above it
	typedef struct packed {
		logic [6:0] rsvd;
		logic [2:0] pal;
		logic [5:0] tile;
	} map_entry_t;

	// Steered read word seen as a tilemap entry in the low halfword
	typedef struct packed {
		logic [15:0] upper;
		map_entry_t  entry;
	} map_word_t;

	// The same steered word is decoded as a map entry or as pixel bytes
	// Byte 0 always holds the addressed byte after steering
	typedef union packed {
		map_word_t       map;
		logic [3:0][7:0] bytes;
	} fetch_word_u;

endpackage

`default_nettype wire

//--- source/ahbl_pkg.sv
`default_nettype none

package ahbl_pkg;

	// Transfer type on htrans
	// Only single transfers are made, so BUSY and SEQ never appear
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_NONSEQ = 2'b10
	} htrans_t;

	// Transfer size on hsize
	// Requesters drive only the low two bits, the top bit is always zero
	typedef enum logic [2:0] {
		HSIZE_BYTE = 3'b000,
		HSIZE_HALF = 3'b001,
		HSIZE_WORD = 3'b010
	} hsize_t;

endpackage

`default_nettype wire

//--- source/ppu_bus_defines.svh
`ifndef PPU_BUS_DEFINES_SVH
`define PPU_BUS_DEFINES_SVH

// Number of fetch requesters sharing the bus master
// Requester 0 is the palette fetcher and requester 1 the background fetcher
`define PPU_N_REQ 2

// Bus widths. Lane steering in the bus master assumes 32-bit data
`define PPU_W_ADDR 32
`define PPU_W_DATA 32

// Video RAM depth in 32-bit words, 1 KiB in total
`define PPU_VRAM_WORDS 256

// Byte address map of the video RAM
// Tilemap holds 128 halfword entries, tiles hold one 4-byte row each
`define PPU_MAP_BASE 32'h0000_0000
`define PPU_TILE_BASE 32'h0000_0100
`define PPU_PAL_BASE 32'h0000_0200

`endif
